/* hdl/warp_pkg.sv */
// Sizes and shared types of the warp issue stage
// Instruction word with register and immediate views
// Fetch, issue and write-back payloads, scoreboard table layout

`default_nettype none

package warp_pkg;

  localparam int WARP_NUM = 4;
  localparam int WARP_W   = $clog2(WARP_NUM);
  localparam int SB_SIZE  = 4;
  localparam int REG_W    = 5;

  typedef logic [WARP_W-1:0]   warp_id_t;
  typedef logic [REG_W-1:0]    reg_id_t;
  typedef logic [WARP_NUM-1:0] warp_mask_t;

  typedef enum logic {
    FORM_REG = 1'b0,
    FORM_IMM = 1'b1
  } inst_form_t;

  // Form bit and rd line up in both views
  // rs1 overlaps the top of the immediate
  typedef struct packed {
    inst_form_t  form;
    reg_id_t     rd;
    reg_id_t     rs1;
    reg_id_t     rs2;
    logic [5:0]  funct;
    logic [9:0]  pad;
  } reg_view_t;

  typedef struct packed {
    inst_form_t  form;
    reg_id_t     rd;
    logic [15:0] imm;
    logic [9:0]  pad;
  } imm_view_t;

  typedef union packed {
    reg_view_t reg_view;
    imm_view_t imm_view;
  } inst_u;

  typedef inst_u [WARP_NUM-1:0] inst_arr_t;

  typedef struct packed {
    warp_id_t warp;
    inst_u    inst;
  } fetch_t;

  typedef struct packed {
    warp_id_t warp;
    inst_u    inst;
  } issue_t;

  typedef struct packed {
    warp_id_t warp;
    reg_id_t  rd;
  } wb_t;

  // One pending destination register
  typedef struct packed {
    logic    valid;
    reg_id_t tag;
  } sb_entry_t;

  typedef sb_entry_t [SB_SIZE-1:0] sb_row_t;
  typedef sb_row_t [WARP_NUM-1:0]  sb_table_t;

endpackage

`default_nettype wire

/* hdl/warp_ibuffer.sv */
// Instruction buffer with one slot per warp
// Filled by the fetch strobe, emptied when the scheduler issues

`timescale 1ns/1ps
`default_nettype none

module warp_ibuffer
  import warp_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       fetch_valid,
  input  fetch_t     fetch,

  input  logic       issue_clear,
  input  warp_id_t   issue_warp,

  output warp_mask_t slot_valid,
  output inst_arr_t  slot_inst
);

  warp_mask_t load_mask;
  warp_mask_t clear_mask;

  // Decode the two strobes into per-warp masks
  // A fetch only lands in an empty slot, so a same-cycle clear wins
  always_comb begin
    load_mask  = '0;
    clear_mask = '0;
    for (int w = 0; w < WARP_NUM; w++) begin
      if (fetch_valid && fetch.warp == warp_id_t'(w) && !slot_valid[w]) begin
        load_mask[w] = 1'b1;
      end
      if (issue_clear && issue_warp == warp_id_t'(w)) begin
        clear_mask[w] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid <= '0;
    end else begin
      slot_valid <= (slot_valid & ~clear_mask) | load_mask;
    end
  end

  // Instruction storage
  always_ff @(posedge clk) begin
    for (int w = 0; w < WARP_NUM; w++) begin
      if (load_mask[w]) begin
        slot_inst[w] <= fetch.inst;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/warp_scoreboard.sv */
// Per-warp scoreboard of pending destination registers
// Set by the scheduler on issue, cleared by write-back tag match

`timescale 1ns/1ps
`default_nettype none

module warp_scoreboard
  import warp_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  logic      sb_set,
  input  warp_id_t  sb_warp,
  input  reg_id_t   sb_rd,

  input  logic      wb_valid,
  input  wb_t       wb,

  output sb_table_t pending
);

  logic    [WARP_NUM-1:0][SB_SIZE-1:0] ent_valid;
  logic    [WARP_NUM-1:0][SB_SIZE-1:0] valid_nxt;
  reg_id_t [WARP_NUM-1:0][SB_SIZE-1:0] ent_tag;

  logic [SB_SIZE-1:0] set_onehot;
  logic [SB_SIZE-1:0] clr_mask;
  logic               set_found;

  // Lowest free entry in the target warp
  always_comb begin
    set_onehot = '0;
    set_found  = 1'b0;
    for (int e = 0; e < SB_SIZE; e++) begin
      if (sb_set && !set_found && !ent_valid[sb_warp][e]) begin
        set_onehot[e] = 1'b1;
        set_found     = 1'b1;
      end
    end
  end

  // Entries retired by write-back; rd 0 is never tracked
  always_comb begin
    clr_mask = '0;
    for (int e = 0; e < SB_SIZE; e++) begin
      clr_mask[e] = wb_valid && (wb.rd != '0) && ent_valid[wb.warp][e] &&
                    (ent_tag[wb.warp][e] == wb.rd);
    end
  end

  // Set and clear touch different entries, both apply in one cycle
  always_comb begin
    valid_nxt          = ent_valid;
    valid_nxt[wb.warp] = valid_nxt[wb.warp] & ~clr_mask;
    valid_nxt[sb_warp] = valid_nxt[sb_warp] | set_onehot;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_valid <= '0;
    end else begin
      ent_valid <= valid_nxt;
    end
  end

  always_ff @(posedge clk) begin
    for (int e = 0; e < SB_SIZE; e++) begin
      if (set_onehot[e]) begin
        ent_tag[sb_warp][e] <= sb_rd;
      end
    end
  end

  always_comb begin
    for (int w = 0; w < WARP_NUM; w++) begin
      for (int e = 0; e < SB_SIZE; e++) begin
        pending[w][e].valid = ent_valid[w][e];
        pending[w][e].tag   = ent_tag[w][e];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/warp_scheduler.sv */
// Warp scheduler with hazard check, round-robin pick and issue FSM
// SELECT latches a warp, ISSUE fires all side effects on one edge

`timescale 1ns/1ps
`default_nettype none

module warp_scheduler
  import warp_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rdy,

  input  warp_mask_t slot_valid,
  input  inst_arr_t  slot_inst,
  input  sb_table_t  pending,

  output logic       issue_clear,
  output warp_id_t   issue_warp,

  output logic       sb_set,
  output warp_id_t   sb_warp,
  output reg_id_t    sb_rd,

  output logic       issue_valid,
  output issue_t     issue
);

  typedef enum logic {
    ST_SELECT = 1'b0,
    ST_ISSUE  = 1'b1
  } state_t;

  state_t     state;
  warp_id_t   last_warp;
  warp_id_t   next_warp;
  warp_id_t   sel_warp;
  inst_u      sel_inst;
  warp_mask_t eligible;
  logic       any_elig;
  logic       issue_fire;

  // Register r is waiting on a write-back in this row
  function automatic logic reg_busy(sb_row_t row, reg_id_t r);
    logic hit;
    hit = 1'b0;
    for (int e = 0; e < SB_SIZE; e++) begin
      if (row[e].valid && row[e].tag == r) begin
        hit = 1'b1;
      end
    end
    return hit && (r != '0);
  endfunction

  function automatic logic row_full(sb_row_t row);
    logic full;
    full = 1'b1;
    for (int e = 0; e < SB_SIZE; e++) begin
      full = full & row[e].valid;
    end
    return full;
  endfunction

  for (genvar w = 0; w < WARP_NUM; w++) begin : gen_elig
    inst_u cur;
    logic  rd_ok;
    logic  src_ok;

    assign cur = slot_inst[w];

    // Destination needs a free entry and no WAW hazard
    assign rd_ok = (cur.reg_view.rd == '0) ||
                   (!reg_busy(pending[w], cur.reg_view.rd) && !row_full(pending[w]));

    // Sources only count in the register form
    assign src_ok = (cur.reg_view.form == FORM_IMM) ||
                    (!reg_busy(pending[w], cur.reg_view.rs1) &&
                     !reg_busy(pending[w], cur.reg_view.rs2));

    assign eligible[w] = slot_valid[w] && rd_ok && src_ok;
  end

  // Search starts one past the last issued warp and wraps
  always_comb begin
    warp_id_t idx;
    logic     found;
    next_warp = last_warp;
    found     = 1'b0;
    for (int k = 1; k <= WARP_NUM; k++) begin
      idx = last_warp + warp_id_t'(k);
      if (!found && eligible[idx]) begin
        next_warp = idx;
        found     = 1'b1;
      end
    end
  end

  assign any_elig   = |eligible;
  assign issue_fire = rdy && (state == ST_ISSUE);

  assign issue_clear = issue_fire;
  assign issue_warp  = sel_warp;
  assign sb_set      = issue_fire && (sel_inst.reg_view.rd != '0);
  assign sb_warp     = sel_warp;
  assign sb_rd       = sel_inst.reg_view.rd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ST_SELECT;
      last_warp   <= warp_id_t'(WARP_NUM - 1);
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= 1'b0;
      if (rdy) begin
        case (state)
          ST_SELECT: begin
            if (any_elig) begin
              state <= ST_ISSUE;
            end
          end
          ST_ISSUE: begin
            issue_valid <= 1'b1;
            last_warp   <= sel_warp;
            state       <= ST_SELECT;
          end
        endcase
      end
    end
  end

  // Latched selection and outgoing instruction
  always_ff @(posedge clk) begin
    if (rdy && state == ST_SELECT && any_elig) begin
      sel_warp <= next_warp;
      sel_inst <= slot_inst[next_warp];
    end
    if (issue_fire) begin
      issue.warp <= sel_warp;
      issue.inst <= sel_inst;
    end
  end

endmodule

`default_nettype wire

/* hdl/warp_issue_top.sv */
// Issue stage top level
// Instruction buffer, scoreboard and scheduler wired together

`timescale 1ns/1ps
`default_nettype none

module warp_issue_top
  import warp_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rdy,

  input  logic       fetch_valid,
  input  fetch_t     fetch,
  output warp_mask_t slot_full,

  input  logic       wb_valid,
  input  wb_t        wb,

  output logic       issue_valid,
  output issue_t     issue
);

  inst_arr_t slot_inst;
  sb_table_t pending;
  logic      issue_clear;
  warp_id_t  issue_warp;
  logic      sb_set;
  warp_id_t  sb_warp;
  reg_id_t   sb_rd;

  // Slot occupancy goes straight out as slot_full
  warp_ibuffer u_ibuffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .issue_clear (issue_clear),
    .issue_warp  (issue_warp),
    .slot_valid  (slot_full),
    .slot_inst   (slot_inst)
  );

  warp_scoreboard u_scoreboard (
    .clk      (clk),
    .rst_n    (rst_n),
    .sb_set   (sb_set),
    .sb_warp  (sb_warp),
    .sb_rd    (sb_rd),
    .wb_valid (wb_valid),
    .wb       (wb),
    .pending  (pending)
  );

  warp_scheduler u_scheduler (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdy         (rdy),
    .slot_valid  (slot_full),
    .slot_inst   (slot_inst),
    .pending     (pending),
    .issue_clear (issue_clear),
    .issue_warp  (issue_warp),
    .sb_set      (sb_set),
    .sb_warp     (sb_warp),
    .sb_rd       (sb_rd),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

endmodule

`default_nettype wire

/* tests/warp_issue_assert.sv */
// Concurrent checks on the issue stage ports
// Bound into warp_issue_top from the testbench

`timescale 1ns/1ps
`default_nettype none

module warp_issue_assert (
  input logic clk,
  input logic rst_n,
  input logic rdy,
  input logic issue_valid
);

  // Issue is a single-cycle pulse
  property issue_single_pulse;
    @(posedge clk) disable iff (!rst_n)
      issue_valid |=> !issue_valid;
  endproperty

  // rdy low at an edge freezes the FSM, nothing goes out after it
  property issue_held_by_rdy;
    @(posedge clk) disable iff (!rst_n)
      !rdy |=> !issue_valid;
  endproperty

  property issue_quiet_in_reset;
    @(posedge clk) !rst_n |-> !issue_valid;
  endproperty

  a_single_pulse: assert property (issue_single_pulse)
    else $error("issue_valid high in two consecutive cycles");

  a_held_by_rdy: assert property (issue_held_by_rdy)
    else $error("issue_valid high after an edge with rdy low");

  a_quiet_in_reset: assert property (issue_quiet_in_reset)
    else $error("issue_valid high during reset");

endmodule

`default_nettype wire

/* tests/tb_warp_issue.sv */
// Testbench for the warp issue stage
// Clock, reset, fetch and write-back drivers, typed result checks
// Directed tests for timing, round robin, hazards, form decode and stalls

`timescale 1ns/1ps
`default_nettype none

module tb_warp_issue
  import warp_pkg::*;
();

  logic       clk;
  logic       rst_n;
  logic       rdy;
  logic       fetch_valid;
  fetch_t     fetch;
  warp_mask_t slot_full;
  logic       wb_valid;
  wb_t        wb;
  logic       issue_valid;
  issue_t     issue;
  integer     seed;

  warp_issue_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdy         (rdy),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .slot_full   (slot_full),
    .wb_valid    (wb_valid),
    .wb          (wb),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

  bind warp_issue_top warp_issue_assert u_issue_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdy         (rdy),
    .issue_valid (issue_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Something failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_issue(input string name, input issue_t exp, input issue_t act);
    if (act !== exp) begin
      $display("Error %s: expected warp %0d inst %h, actual warp %0d inst %h",
               name, exp.warp, exp.inst, act.warp, act.inst);
      stop_on_failure();
    end
  endtask

  task automatic check_mask(input string name, input warp_mask_t exp, input warp_mask_t act);
    if (act !== exp) begin
      $display("Error %s: expected slot mask %b, actual %b", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Error %s: expected %0d cycles to issue, actual %0d", name, exp, act);
      stop_on_failure();
    end
  endtask

  // Outputs are sampled and inputs driven 1 ns after each rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic inst_u reg_inst(input reg_id_t rd, input reg_id_t rs1, input reg_id_t rs2);
    inst_u i;
    i = '0;
    i.reg_view.form  = FORM_REG;
    i.reg_view.rd    = rd;
    i.reg_view.rs1   = rs1;
    i.reg_view.rs2   = rs2;
    i.reg_view.funct = 6'($random(seed));
    return i;
  endfunction

  function automatic inst_u imm_inst(input reg_id_t rd, input logic [15:0] imm);
    inst_u i;
    i = '0;
    i.imm_view.form = FORM_IMM;
    i.imm_view.rd   = rd;
    i.imm_view.imm  = imm;
    return i;
  endfunction

  function automatic issue_t expected_issue(input warp_id_t w, input inst_u i);
    issue_t e;
    e.warp = w;
    e.inst = i;
    return e;
  endfunction

  task automatic send_fetch(input warp_id_t w, input inst_u i);
    fetch_valid = 1'b1;
    fetch.warp  = w;
    fetch.inst  = i;
    next_cycle();
    fetch_valid = 1'b0;
  endtask

  task automatic send_wb(input warp_id_t w, input reg_id_t rd);
    wb_valid = 1'b1;
    wb.warp  = w;
    wb.rd    = rd;
    next_cycle();
    wb_valid = 1'b0;
  endtask

  task automatic wait_issue(input string name, input issue_t exp, output int cycles);
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < 20) begin
      next_cycle();
      cycles++;
      seen = issue_valid;
    end
    if (!seen) begin
      $display("Timeout in %s: no instruction issued within 20 cycles", name);
      stop_on_failure();
    end
    check_issue(name, exp, issue);
  endtask

  task automatic expect_no_issue(input string name, input int n);
    repeat (n) begin
      next_cycle();
      if (issue_valid) begin
        $display("%s: warp %0d issued while it should be blocked", name, issue.warp);
        stop_on_failure();
      end
    end
  endtask

  // Idle scheduler issues exactly two edges after the fetch edge
  task automatic issue_after_fetch(input string name, input warp_id_t w, input inst_u i);
    int cycles;
    send_fetch(w, i);
    wait_issue(name, expected_issue(w, i), cycles);
    check_cycles(name, 2, cycles);
  endtask

  task automatic hold_rdy_low(input int n);
    rdy = 1'b0;
    expect_no_issue("rdy low", n);
    rdy = 1'b1;
  endtask

  task automatic round_robin_order();
    inst_u ins [WARP_NUM];
    int    cycles;
    rdy = 1'b0;
    for (int w = 0; w < WARP_NUM; w++) begin
      ins[w] = imm_inst(5'd0, 16'($random(seed)));
      send_fetch(warp_id_t'(w), ins[w]);
    end
    check_mask("round robin fill", '1, slot_full);
    rdy = 1'b1;
    for (int w = 0; w < WARP_NUM; w++) begin
      wait_issue("round robin first pass", expected_issue(warp_id_t'(w), ins[w]), cycles);
    end
    // Search resumes after warp 3, so warp 0 goes first
    rdy = 1'b0;
    ins[3] = imm_inst(5'd0, 16'($random(seed)));
    send_fetch(2'd3, ins[3]);
    ins[0] = imm_inst(5'd0, 16'($random(seed)));
    send_fetch(2'd0, ins[0]);
    check_mask("round robin refill", 4'b1001, slot_full);
    rdy = 1'b1;
    wait_issue("round robin refill warp 0", expected_issue(2'd0, ins[0]), cycles);
    wait_issue("round robin refill warp 3", expected_issue(2'd3, ins[3]), cycles);
  endtask

  task automatic single_issue();
    inst_u ins;
    int    cycles;
    ins = reg_inst(5'd3, 5'd1, 5'd2);
    send_fetch(2'd2, ins);
    check_mask("single reg fetch", 4'b0100, slot_full);
    wait_issue("single reg form", expected_issue(2'd2, ins), cycles);
    check_cycles("single reg form", 2, cycles);
    check_mask("single reg cleared", '0, slot_full);
    send_wb(2'd2, 5'd3);
    ins = imm_inst(5'd4, 16'($random(seed)));
    send_fetch(2'd2, ins);
    check_mask("single imm fetch", 4'b0100, slot_full);
    wait_issue("single imm form", expected_issue(2'd2, ins), cycles);
    check_cycles("single imm form", 2, cycles);
    check_mask("single imm cleared", '0, slot_full);
    send_wb(2'd2, 5'd4);
  endtask

  task automatic waw_hazard();
    inst_u ins;
    int    cycles;
    issue_after_fetch("waw first", 2'd1, imm_inst(5'd5, 16'($random(seed))));
    ins = imm_inst(5'd5, 16'($random(seed)));
    send_fetch(2'd1, ins);
    expect_no_issue("waw blocked", 10);
    send_wb(2'd1, 5'd5);
    wait_issue("waw after wb", expected_issue(2'd1, ins), cycles);
    check_cycles("waw after wb", 2, cycles);
    send_wb(2'd1, 5'd5);
  endtask

  task automatic raw_and_decode();
    inst_u ins;
    int    cycles;
    issue_after_fetch("raw producer", 2'd0, imm_inst(5'd7, 16'($random(seed))));
    // Immediate bits sit where rs1 and rs2 would be, and hold r7
    ins = imm_inst(5'd9, {5'd7, 5'd7, 6'($random(seed))});
    issue_after_fetch("imm form ignores sources", 2'd0, ins);
    ins = reg_inst(5'd8, 5'd7, 5'd0);
    send_fetch(2'd0, ins);
    expect_no_issue("raw blocked", 10);
    send_wb(2'd0, 5'd7);
    wait_issue("raw after wb", expected_issue(2'd0, ins), cycles);
    check_cycles("raw after wb", 2, cycles);
    issue_after_fetch("rd zero", 2'd0, reg_inst(5'd0, 5'd0, 5'd0));
    issue_after_fetch("rd zero again", 2'd0, reg_inst(5'd0, 5'd0, 5'd0));
    // With r8 and r9 pending, r10 only finds room if rd 0 took no entry
    issue_after_fetch("rd zero takes no entry", 2'd0, imm_inst(5'd10, 16'($random(seed))));
    send_wb(2'd0, 5'd8);
    send_wb(2'd0, 5'd9);
    send_wb(2'd0, 5'd10);
  endtask

  task automatic scoreboard_full();
    inst_u ins;
    int    cycles;
    for (int k = 10; k < 10 + SB_SIZE; k++) begin
      issue_after_fetch("fill scoreboard", 2'd3, imm_inst(reg_id_t'(k), 16'($random(seed))));
    end
    issue_after_fetch("rd zero on full scoreboard", 2'd3, imm_inst(5'd0, 16'($random(seed))));
    ins = imm_inst(5'd14, 16'($random(seed)));
    send_fetch(2'd3, ins);
    expect_no_issue("full scoreboard blocked", 10);
    check_mask("full scoreboard slot held", 4'b1000, slot_full);
    send_wb(2'd3, 5'd10);
    wait_issue("full scoreboard after wb", expected_issue(2'd3, ins), cycles);
    check_cycles("full scoreboard after wb", 2, cycles);
    for (int k = 11; k <= 14; k++) begin
      send_wb(2'd3, reg_id_t'(k));
    end
  endtask

  task automatic rdy_stall();
    inst_u ins;
    int    cycles;
    // Back-pressure before the selection edge
    ins = imm_inst(5'd0, 16'($random(seed)));
    send_fetch(2'd1, ins);
    hold_rdy_low(3);
    wait_issue("stall in select", expected_issue(2'd1, ins), cycles);
    check_cycles("stall in select", 5, 3 + cycles);
    // Back-pressure while the selected warp waits to issue
    ins = imm_inst(5'd0, 16'($random(seed)));
    send_fetch(2'd1, ins);
    next_cycle();
    hold_rdy_low(4);
    wait_issue("stall in issue", expected_issue(2'd1, ins), cycles);
    check_cycles("stall in issue", 6, 1 + 4 + cycles);
  endtask

  initial begin
    seed        = 32'ha729c856;
    rst_n       = 1'b1;
    rdy         = 1'b0;
    fetch_valid = 1'b0;
    fetch       = '0;
    wb_valid    = 1'b0;
    wb          = '0;
    #2;
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    rdy   = 1'b1;
    check_mask("after reset", '0, slot_full);
    if (issue_valid) begin
      $display("issue_valid is high right after reset");
      stop_on_failure();
    end
    round_robin_order();
    single_issue();
    waw_hazard();
    raw_and_decode();
    scoreboard_full();
    rdy_stall();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
hdl/warp_pkg.sv
hdl/warp_ibuffer.sv
hdl/warp_scoreboard.sv
hdl/warp_scheduler.sv
hdl/warp_issue_top.sv
tests/warp_issue_assert.sv
tests/tb_warp_issue.sv

/* Makefile */
# Verilator build and run of the warp issue stage testbench

TOP := tb_warp_issue

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f hdl/*.sv tests/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --top-module warp_issue_top -f compile.f

clean:
	rm -rf obj_dir
